// ==== common/sysctl_pkg.sv ====
// Shared definitions for the system controller.
// Holds the bus and strobe structs, the register map and the constants that
// every block of the controller and its testbench import.

package sysctl_pkg;

	////////////////////////////////////////////////////////////
	// Constants
	////////////////////////////////////////////////////////////
	localparam int CSR_ADDR_WIDTH = 14; // Word address of the CSR bus.
	localparam int CSR_DATA_WIDTH = 32; // Data width of the CSR bus.
	localparam logic [3:0] CSR_BANK = 4'h0; // Bank that selects this controller.
	localparam int GPIO_WIDTH = 16; // Number of GPIO inputs and outputs.
	localparam int TIMER_WIDTH = 32; // Counter and compare width.
	localparam int SCRATCH_WIDTH = 8; // Debug scratchpad width.
	localparam int CMD_WIDTH = 16; // Reconfiguration command word width.
	localparam int CMD_BUSY_CYCLES = 4; // Cycles one command occupies the port.
	localparam int CMD_CNT_WIDTH = $clog2(CMD_BUSY_CYCLES); // Busy counter width.
	localparam logic [31:0] CLK_FREQ = 32'd25_000_000; // System clock in Hz.
	localparam logic [31:0] SYSTEM_ID = 32'h5343_3031; // Identity word.

	////////////////////////////////////////////////////////////
	// Register map and states
	////////////////////////////////////////////////////////////
	typedef enum logic [4:0] {
		gpio_in      = 5'd0,  // Read only.
		gpio_out     = 5'd1,
		gpio_irqen   = 5'd2,
		t0_ctrl      = 5'd4,  // Bit 0 enable, bit 1 auto-reload.
		t0_compare   = 5'd5,
		t0_counter   = 5'd6,
		t1_ctrl      = 5'd8,
		t1_compare   = 5'd9,
		t1_counter   = 5'd10,
		cmd          = 5'd16, // Write starts a command, read gives ready.
		scratch      = 5'd20,
		debug_ctrl   = 5'd21, // Bit 0 sets the write lock, bit 1 bus errors.
		clk_freq     = 5'd29, // Read only.
		capabilities = 5'd30, // Read only.
		system_id    = 5'd31  // A write requests a hard reset.
	} csr_reg_e;

	typedef enum logic {
		idle,
		busy
	} cmd_state_e;

	////////////////////////////////////////////////////////////
	// Structs
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [CSR_ADDR_WIDTH-1:0] addr; // Upper four bits are the bank.
		logic we;
		logic [CSR_DATA_WIDTH-1:0] data;
	} csr_req_t;

	typedef struct packed {
		logic out_we;   // Loads the output register.
		logic irqen_we; // Loads the interrupt enables.
		logic [GPIO_WIDTH-1:0] data;
	} gpio_wr_t;

	typedef struct packed {
		logic [GPIO_WIDTH-1:0] pins_in; // Synchronized inputs.
		logic [GPIO_WIDTH-1:0] pins_out;
		logic [GPIO_WIDTH-1:0] irqen;
	} gpio_stat_t;

	typedef struct packed {
		logic ctrl_we;
		logic compare_we;
		logic counter_we;
		logic [TIMER_WIDTH-1:0] data;
	} timer_wr_t;

	typedef struct packed {
		logic en;
		logic ar;
		logic [TIMER_WIDTH-1:0] compare;
		logic [TIMER_WIDTH-1:0] counter;
	} timer_stat_t;

	typedef struct packed {
		logic start; // One-cycle write strobe on the cmd register.
		logic ce;
		logic write;
		logic [CMD_WIDTH-1:0] word;
	} cmd_req_t;

endpackage

// ==== gpio/sysctl_gpio.sv ====
// General-purpose I/O block of the system controller.
// Synchronizes the input pins, raises a one-cycle interrupt on any enabled
// level change and holds the output register written over the CSR bus.

`timescale 1ns/1ps

module sysctl_gpio
	import sysctl_pkg::*;
(
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic [GPIO_WIDTH-1:0] pins_in,
	input  gpio_wr_t wr,
	output logic [GPIO_WIDTH-1:0] pins_out,
	output gpio_stat_t stat,
	output logic irq
);

	logic [GPIO_WIDTH-1:0] sync0; // First stage, may be metastable.
	logic [GPIO_WIDTH-1:0] sync1; // Stable input value seen by software.
	logic [GPIO_WIDTH-1:0] prev; // Value of sync1 one cycle earlier.
	logic [GPIO_WIDTH-1:0] irqen; // Per-input interrupt enables.
	logic [GPIO_WIDTH-1:0] changed;

	////////////////////////////////////////////////////////////
	// Input path
	////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk) begin
		sync0 <= pins_in; // Two flops before any logic looks at a pin.
		sync1 <= sync0;
		prev <= sync1;
	end

	assign changed = (sync1 ^ prev) & irqen; // Only enabled inputs count.

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			irq <= 1'b0;
		end else begin
			irq <= |changed; // High for one cycle per change.
		end
	end

	////////////////////////////////////////////////////////////
	// Output and enable registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pins_out <= '0; // Outputs come up low.
			irqen <= '0; // No interrupts until software asks.
		end else begin
			if (wr.out_we) pins_out <= wr.data;
			if (wr.irqen_we) irqen <= wr.data;
		end
	end

	assign stat.pins_in = sync1;
	assign stat.pins_out = pins_out;
	assign stat.irqen = irqen;

endmodule

// ==== timer/sysctl_timer.sv ====
// One 32-bit timer of the system controller; the top level has two of them.
// Counts up while enabled, pulses irq for one cycle when the counter meets
// the compare value, then reloads to 1 or stops according to auto-reload.

`timescale 1ns/1ps

module sysctl_timer
	import sysctl_pkg::*;
(
	input  logic sys_clk,
	input  logic sys_rst,
	input  timer_wr_t wr,
	output timer_stat_t stat,
	output logic irq
);

	logic en; // Timer runs while set.
	logic ar; // Auto-reload on match.
	logic [TIMER_WIDTH-1:0] compare;
	logic [TIMER_WIDTH-1:0] counter;
	logic match;

	assign match = (counter == compare); // Combinational, used in the same cycle.

	////////////////////////////////////////////////////////////
	// Counter and control
	////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			en <= 1'b0;
			ar <= 1'b0;
			compare <= '1; // Farthest possible match.
			counter <= '0;
			irq <= 1'b0;
		end else begin
			irq <= en & match; // Exactly one cycle per match.

			if (en & ~match) begin
				counter <= counter + 1'b1; // Count toward the compare value.
			end

			if (en & match) begin
				if (ar) begin
					counter <= TIMER_WIDTH'(1); // Next period starts at 1.
				end else begin
					en <= 1'b0; // One-shot is done.
				end
			end

			// Bus writes come last so they win over the counting above.
			if (wr.ctrl_we) begin
				en <= wr.data[0];
				ar <= wr.data[1];
			end
			if (wr.compare_we) begin
				compare <= wr.data;
			end
			if (wr.counter_we) begin
				counter <= wr.data; // Overrides an increment or reload.
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Status
	////////////////////////////////////////////////////////////
	assign stat.en = en;
	assign stat.ar = ar;
	assign stat.compare = compare;
	assign stat.counter = counter;

endmodule

// ==== source/sysctl_cmdport.sv ====
// Reconfiguration command port.
// An accepted start latches the command word and drives it out for
// CMD_BUSY_CYCLES cycles with cmd_strobe high; ready is low meanwhile.

`timescale 1ns/1ps

module sysctl_cmdport
	import sysctl_pkg::*;
(
	input  logic sys_clk,
	input  logic sys_rst,
	input  cmd_req_t req,
	output logic ready,
	output logic cmd_strobe,
	output logic cmd_ce,
	output logic cmd_write,
	output logic [CMD_WIDTH-1:0] cmd_data
);

	cmd_state_e state;
	logic [CMD_CNT_WIDTH-1:0] cnt; // Cycles left in the busy phase.
	cmd_req_t lat; // Command latched at the start.

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= idle;
			cnt <= '0;
		end else begin
			case (state)
				idle: begin
					if (req.start) begin
						state <= busy; // Ready falls at this edge.
						cnt <= CMD_CNT_WIDTH'(CMD_BUSY_CYCLES - 1);
					end
				end
				busy: begin
					if (cnt == '0) begin
						state <= idle; // Last busy cycle is over.
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == idle && req.start) lat <= req; // Starts while busy are dropped.
	end

	assign ready = (state == idle);
	assign cmd_strobe = (state == busy);
	assign cmd_ce = cmd_strobe & lat.ce; // Port is quiet while idle.
	assign cmd_write = cmd_strobe & lat.write;
	assign cmd_data = lat.word;

endmodule

// ==== source/sysctl_csr.sv ====
// Register bank of the system controller on the CSR bus.
// Decodes the bank and offset into write strobes for the GPIO, timer and
// command blocks, owns the debug and reset controls, and registers the
// read data so that it appears one cycle after the address.

`timescale 1ns/1ps

module sysctl_csr
	import sysctl_pkg::*;
(
	input  logic sys_clk,
	input  logic sys_rst,
	input  csr_req_t req,
	input  logic [31:0] capabilities,
	input  gpio_stat_t gpio_stat,
	input  timer_stat_t t0_stat,
	input  timer_stat_t t1_stat,
	input  logic cmd_ready,
	output logic [CSR_DATA_WIDTH-1:0] rdata,
	output gpio_wr_t gpio_wr,
	output timer_wr_t t0_wr,
	output timer_wr_t t1_wr,
	output cmd_req_t cmd_req,
	output logic debug_write_lock,
	output logic bus_errors_en,
	output logic hard_reset
);

	logic selected; // Bank matches this controller.
	logic wr_en; // Selected write in this cycle.
	csr_reg_e offset; // Register within the bank.
	logic [SCRATCH_WIDTH-1:0] scratchpad;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	assign selected = (req.addr[CSR_ADDR_WIDTH-1:CSR_ADDR_WIDTH-4] == CSR_BANK);
	assign wr_en = selected & req.we;
	assign offset = csr_reg_e'(req.addr[4:0]); // Bits 9:5 are ignored.

	// GPIO strobes.
	assign gpio_wr.out_we = wr_en & (offset == gpio_out);
	assign gpio_wr.irqen_we = wr_en & (offset == gpio_irqen);
	assign gpio_wr.data = req.data[GPIO_WIDTH-1:0];

	// Timer strobes, one set per timer.
	assign t0_wr.ctrl_we = wr_en & (offset == t0_ctrl);
	assign t0_wr.compare_we = wr_en & (offset == t0_compare);
	assign t0_wr.counter_we = wr_en & (offset == t0_counter);
	assign t0_wr.data = req.data[TIMER_WIDTH-1:0];
	assign t1_wr.ctrl_we = wr_en & (offset == t1_ctrl);
	assign t1_wr.compare_we = wr_en & (offset == t1_compare);
	assign t1_wr.counter_we = wr_en & (offset == t1_counter);
	assign t1_wr.data = req.data[TIMER_WIDTH-1:0];

	// The command port itself drops a start that arrives while busy.
	assign cmd_req.start = wr_en & (offset == cmd);
	assign cmd_req.ce = req.data[16];
	assign cmd_req.write = req.data[17];
	assign cmd_req.word = req.data[CMD_WIDTH-1:0];

	////////////////////////////////////////////////////////////
	// Control registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			debug_write_lock <= 1'b0;
			bus_errors_en <= 1'b0;
			hard_reset <= 1'b0;
		end else if (wr_en) begin
			if (offset == debug_ctrl) begin
				if (req.data[0]) debug_write_lock <= 1'b1; // Sticky until reset.
				bus_errors_en <= req.data[1];
			end
			if (offset == system_id) begin
				hard_reset <= 1'b1; // Held until the SoC resets us.
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_en && offset == scratch) begin
			scratchpad <= req.data[SCRATCH_WIDTH-1:0]; // Free for the debugger.
		end
	end

	////////////////////////////////////////////////////////////
	// Read multiplexer
	////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rdata <= '0;
		end else if (!selected) begin
			rdata <= '0; // Other banks see nothing from us.
		end else begin
			case (offset)
				gpio_in: rdata <= CSR_DATA_WIDTH'(gpio_stat.pins_in);
				gpio_out: rdata <= CSR_DATA_WIDTH'(gpio_stat.pins_out);
				gpio_irqen: rdata <= CSR_DATA_WIDTH'(gpio_stat.irqen);
				t0_ctrl: rdata <= CSR_DATA_WIDTH'({t0_stat.ar, t0_stat.en});
				t0_compare: rdata <= CSR_DATA_WIDTH'(t0_stat.compare);
				t0_counter: rdata <= CSR_DATA_WIDTH'(t0_stat.counter);
				t1_ctrl: rdata <= CSR_DATA_WIDTH'({t1_stat.ar, t1_stat.en});
				t1_compare: rdata <= CSR_DATA_WIDTH'(t1_stat.compare);
				t1_counter: rdata <= CSR_DATA_WIDTH'(t1_stat.counter);
				cmd: rdata <= CSR_DATA_WIDTH'(cmd_ready);
				scratch: rdata <= CSR_DATA_WIDTH'(scratchpad);
				debug_ctrl: rdata <= CSR_DATA_WIDTH'({bus_errors_en, debug_write_lock});
				clk_freq: rdata <= CLK_FREQ;
				sysctl_pkg::capabilities: rdata <= capabilities; // Strapped at the top.
				system_id: rdata <= SYSTEM_ID;
				default: rdata <= '0; // Holes in the map read as zero.
			endcase
		end
	end

endmodule

// ==== source/sysctl.sv ====
// Top level of the system controller.
// Packs the CSR bus pins into a request for the register bank and wires the
// GPIO block, the two timers and the command port to it and to the pins.

`timescale 1ns/1ps

module sysctl
	import sysctl_pkg::*;
(
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic [CSR_ADDR_WIDTH-1:0] csr_a,
	input  logic csr_we,
	input  logic [CSR_DATA_WIDTH-1:0] csr_di,
	output logic [CSR_DATA_WIDTH-1:0] csr_do,
	input  logic [GPIO_WIDTH-1:0] gpio_inputs,
	output logic [GPIO_WIDTH-1:0] gpio_outputs,
	input  logic [31:0] capabilities,
	output logic gpio_irq,
	output logic timer0_irq,
	output logic timer1_irq,
	output logic debug_write_lock,
	output logic bus_errors_en,
	output logic hard_reset,
	output logic cmd_strobe,
	output logic cmd_ce,
	output logic cmd_write,
	output logic [CMD_WIDTH-1:0] cmd_data
);

	csr_req_t csr_req; // Bus pins gathered into one request.
	gpio_wr_t gpio_wr;
	gpio_stat_t gpio_stat;
	timer_wr_t t0_wr;
	timer_wr_t t1_wr;
	timer_stat_t t0_stat;
	timer_stat_t t1_stat;
	cmd_req_t cmd_req;
	logic cmd_ready;

	assign csr_req.addr = csr_a;
	assign csr_req.we = csr_we;
	assign csr_req.data = csr_di;

	sysctl_csr csr_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .req(csr_req),
		.capabilities(capabilities), .gpio_stat(gpio_stat),
		.t0_stat(t0_stat), .t1_stat(t1_stat), .cmd_ready(cmd_ready),
		.rdata(csr_do), .gpio_wr(gpio_wr), .t0_wr(t0_wr), .t1_wr(t1_wr),
		.cmd_req(cmd_req), .debug_write_lock(debug_write_lock),
		.bus_errors_en(bus_errors_en), .hard_reset(hard_reset)
	);

	sysctl_gpio gpio_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .pins_in(gpio_inputs), .wr(gpio_wr),
		.pins_out(gpio_outputs), .stat(gpio_stat), .irq(gpio_irq)
	);

	// The two timers run side by side and never interact.
	sysctl_timer timer0_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .wr(t0_wr), .stat(t0_stat), .irq(timer0_irq)
	);

	sysctl_timer timer1_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .wr(t1_wr), .stat(t1_stat), .irq(timer1_irq)
	);

	sysctl_cmdport cmdport_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .req(cmd_req), .ready(cmd_ready),
		.cmd_strobe(cmd_strobe), .cmd_ce(cmd_ce), .cmd_write(cmd_write),
		.cmd_data(cmd_data)
	);

endmodule

// ==== verification/sysctl_checker.sv ====
// Concurrent assertions for the system controller, bound into sysctl.
// Covers GPIO interrupt timing, timer pulse shape and period, the command
// port's busy window and the sticky control outputs.

`timescale 1ns/1ps

module sysctl_checker
	import sysctl_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst,
	input logic [GPIO_WIDTH-1:0] gpio_inputs,
	input logic gpio_irq,
	input gpio_stat_t gpio_stat,
	input logic timer0_irq,
	input logic timer1_irq,
	input timer_stat_t t1_stat,
	input logic cmd_strobe,
	input logic [CMD_WIDTH-1:0] cmd_data,
	input logic debug_write_lock,
	input logic hard_reset
);

	int failures = 0; // Read by the testbench for its closing line.

	// An enabled pin change gives an interrupt three samples later.
	gpio_irq_follows: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(((gpio_inputs ^ $past(gpio_inputs)) & gpio_stat.irqen) != '0) |-> ##3 gpio_irq)
		else begin failures++; $error("GPIO change without interrupt"); end

	// No interrupt unless an enabled pin really changed.
	gpio_irq_cause: assert property (@(posedge sys_clk) disable iff (sys_rst)
		gpio_irq |-> ((($past(gpio_inputs, 3) ^ $past(gpio_inputs, 4))
			& $past(gpio_stat.irqen, 1)) != '0))
		else begin failures++; $error("GPIO interrupt without enabled change"); end

	timer0_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		timer0_irq |=> !timer0_irq)
		else begin failures++; $error("Timer 0 interrupt longer than one cycle"); end

	// Auto-reload with compare 5 repeats every five cycles.
	timer1_period: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(timer1_irq && t1_stat.ar && t1_stat.compare == 32'd5) |=>
		!timer1_irq ##1 !timer1_irq ##1 !timer1_irq ##1 !timer1_irq
		##1 (timer1_irq || !t1_stat.en))
		else begin failures++; $error("Timer 1 reload period wrong"); end

	cmd_window: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$rose(cmd_strobe) |-> ##(CMD_BUSY_CYCLES-1) cmd_strobe ##1 !cmd_strobe)
		else begin failures++; $error("Command strobe length wrong"); end

	// A start during the busy window must not disturb the word on the port.
	cmd_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(cmd_strobe && $past(cmd_strobe)) |-> $stable(cmd_data))
		else begin failures++; $error("Command word changed while busy"); end

	lock_sticky: assert property (@(posedge sys_clk)
		(!$past(sys_rst) && $past(debug_write_lock)) |-> debug_write_lock)
		else begin failures++; $error("Debug write lock fell without reset"); end

	reset_sticky: assert property (@(posedge sys_clk)
		(!$past(sys_rst) && $past(hard_reset)) |-> hard_reset)
		else begin failures++; $error("Hard reset request fell without reset"); end

endmodule

bind sysctl sysctl_checker checker_i (
	.sys_clk(sys_clk), .sys_rst(sys_rst), .gpio_inputs(gpio_inputs),
	.gpio_irq(gpio_irq), .gpio_stat(gpio_stat), .timer0_irq(timer0_irq),
	.timer1_irq(timer1_irq), .t1_stat(t1_stat), .cmd_strobe(cmd_strobe),
	.cmd_data(cmd_data), .debug_write_lock(debug_write_lock), .hard_reset(hard_reset)
);

// ==== verification/sysctl_tb.sv ====
// Testbench for the system controller.
// Drives the CSR bus and the pins on the falling edge, reads registers back,
// measures interrupt timing and relies on the bound checker for the rest.

`timescale 1ns/1ps

module sysctl_tb
	import sysctl_pkg::*;
;

	localparam int TEST_CYCLES = 150; // Sum of all test phases in clock cycles.

	logic sys_clk, sys_rst, csr_we;
	logic [CSR_ADDR_WIDTH-1:0] csr_a;
	logic [31:0] csr_di, csr_do, capabilities;
	logic [GPIO_WIDTH-1:0] gpio_inputs, gpio_outputs;
	logic gpio_irq, timer0_irq, timer1_irq, debug_write_lock, bus_errors_en;
	logic hard_reset, cmd_strobe, cmd_ce, cmd_write;
	logic [CMD_WIDTH-1:0] cmd_data;
	integer seed = 44;
	int errors = 0;
	int strobe_cycles = 0;
	logic [CMD_WIDTH-1:0] exp_word = '0; // Word the port should be sending.

	sysctl dut_i (.*);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk; // 40 ns period.
	end

	////////////////////////////////////////////////////////////
	// Bus and wait helpers
	////////////////////////////////////////////////////////////
	function automatic logic [CSR_ADDR_WIDTH-1:0] reg_addr(input logic [3:0] bank,
		input csr_reg_e r);
		return {bank, 5'd0, r};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		errors++;
		$display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
	endtask

	task automatic csr_write(input csr_reg_e r, input logic [31:0] data);
		@(negedge sys_clk);
		csr_a = reg_addr(CSR_BANK, r);
		csr_we = 1'b1;
		csr_di = data;
		@(negedge sys_clk);
		csr_we = 1'b0; // Write took effect at the rising edge in between.
	endtask

	task automatic csr_read(input logic [3:0] bank, input csr_reg_e r,
		input logic [31:0] exp, input string name);
		@(negedge sys_clk);
		csr_a = reg_addr(bank, r);
		csr_we = 1'b0;
		@(negedge sys_clk); // Registered data is stable here.
		if (csr_do !== exp) report_mismatch(name, exp, csr_do);
	endtask

	// Counts falling edges until the chosen interrupt is seen high.
	task automatic count_until_high(input int sel, input int limit, output int cycles);
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < limit) begin
			@(negedge sys_clk);
			cycles++;
			case (sel)
				0: seen = timer0_irq;
				1: seen = timer1_irq;
				default: seen = gpio_irq;
			endcase
		end
		if (!seen) begin
			errors++;
			$display("Interrupt %0d never arrived within %0d cycles", sel, limit);
		end
	endtask

	task automatic expect_cycles(input string name, input int exp, input int got);
		if (got != exp) report_mismatch(name, exp, got);
	endtask

	always @(negedge sys_clk) begin
		if (cmd_strobe) begin
			strobe_cycles++; // Sampled away from the rising edge.
			if (cmd_data !== exp_word) report_mismatch("cmd_data", exp_word, cmd_data);
			if (cmd_ce !== 1'b1) report_mismatch("cmd_ce", 1, cmd_ce);
			if (cmd_write !== 1'b1) report_mismatch("cmd_write", 1, cmd_write);
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] v;
		int c;
		int total;
		sys_rst = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		gpio_inputs = '0;
		capabilities = $random(seed);
		repeat (2) @(negedge sys_clk);
		sys_rst = 1'b0;

		// Register read-back, reset values and identity words.
		csr_read(CSR_BANK, t0_compare, '1, "t0_compare reset");
		csr_read(CSR_BANK, cmd, 32'd1, "cmd ready reset");
		v = $random(seed);
		csr_write(scratch, v);
		csr_read(CSR_BANK, scratch, v & 32'hff, "scratch");
		v = $random(seed);
		csr_write(gpio_out, v);
		csr_read(CSR_BANK, gpio_out, v & 32'hffff, "gpio_out");
		if (gpio_outputs !== v[15:0]) report_mismatch("gpio_outputs", v[15:0], gpio_outputs);
		v = $random(seed);
		csr_write(gpio_irqen, v);
		csr_read(CSR_BANK, gpio_irqen, v & 32'hffff, "gpio_irqen");
		v = $random(seed);
		csr_write(t0_compare, v);
		csr_read(CSR_BANK, t0_compare, v, "t0_compare");
		v = $random(seed);
		csr_write(t1_compare, v);
		csr_read(CSR_BANK, t1_compare, v, "t1_compare");
		csr_read(4'h1, system_id, '0, "foreign bank");
		csr_read(CSR_BANK, system_id, SYSTEM_ID, "system_id");
		csr_read(CSR_BANK, clk_freq, CLK_FREQ, "clk_freq");
		csr_read(CSR_BANK, sysctl_pkg::capabilities, capabilities, "capabilities");

		// GPIO interrupt on pin 0 only.
		csr_write(gpio_irqen, 32'h1);
		gpio_inputs = 16'h0001;
		count_until_high(2, 10, c);
		expect_cycles("gpio_irq delay", 3, c);
		gpio_inputs = 16'h0003; // Pin 1 is disabled.
		repeat (6) begin
			@(negedge sys_clk);
			if (gpio_irq) report_mismatch("gpio_irq disabled pin", 0, 1);
		end
		csr_read(CSR_BANK, gpio_in, 32'h3, "gpio_in");

		// Timer 0 one-shot.
		csr_write(t0_compare, 32'd10);
		csr_write(t0_counter, 32'd0);
		csr_write(t0_ctrl, 32'h1);
		count_until_high(0, 40, c);
		expect_cycles("timer0 one-shot delay", 11, c);
		csr_read(CSR_BANK, t0_ctrl, 32'h0, "t0_ctrl after match");
		csr_read(CSR_BANK, t0_counter, 32'd10, "t0_counter after match");

		// Timer 1 auto-reload while timer 0 runs.
		csr_write(t1_compare, 32'd5);
		csr_write(t1_counter, 32'd0);
		csr_write(t0_compare, 32'd40);
		csr_write(t0_counter, 32'd0);
		csr_write(t1_ctrl, 32'h3);
		csr_write(t0_ctrl, 32'h1);
		count_until_high(1, 20, c);
		total = c;
		repeat (3) begin
			count_until_high(1, 20, c);
			expect_cycles("timer1 period", 5, c);
			total += c;
		end
		count_until_high(0, 60, c);
		expect_cycles("timer0 delay beside timer1", 41, total + c);
		csr_write(t1_ctrl, 32'h0);

		// Command port with a dropped second start.
		v = $random(seed);
		exp_word = v[15:0];
		csr_write(cmd, {14'd0, 1'b1, 1'b1, v[15:0]}); // Chip enable and write set.
		csr_write(cmd, {14'd0, 1'b0, 1'b0, ~v[15:0]});
		csr_read(CSR_BANK, cmd, 32'd0, "cmd ready busy");
		csr_read(CSR_BANK, cmd, 32'd1, "cmd ready done");
		expect_cycles("cmd_strobe length", CMD_BUSY_CYCLES, strobe_cycles);

		// Sticky controls, cleared only by reset.
		csr_write(debug_ctrl, 32'h3);
		if (bus_errors_en !== 1'b1) report_mismatch("bus_errors_en set", 1, bus_errors_en);
		csr_write(debug_ctrl, 32'h0);
		if (bus_errors_en !== 1'b0) report_mismatch("bus_errors_en clear", 0, bus_errors_en);
		csr_read(CSR_BANK, debug_ctrl, 32'h1, "debug_ctrl");
		csr_write(system_id, 32'h0);
		repeat (4) @(negedge sys_clk);
		if (hard_reset !== 1'b1) report_mismatch("hard_reset", 1, hard_reset);
		if (debug_write_lock !== 1'b1) report_mismatch("debug_write_lock", 1, debug_write_lock);
		sys_rst = 1'b1;
		repeat (2) @(negedge sys_clk);
		sys_rst = 1'b0;
		if (hard_reset !== 1'b0) report_mismatch("hard_reset after reset", 0, hard_reset);
		if (debug_write_lock !== 1'b0) begin
			report_mismatch("debug_write_lock after reset", 0, debug_write_lock);
		end

		repeat (2) @(negedge sys_clk);
		$display("%0d errors, %0d assertion failures", errors, dut_i.checker_i.failures);
		if (errors == 0 && dut_i.checker_i.failures == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(TEST_CYCLES * 40 * 2);
		$display("Timeout: the simulation did not finish in time");
		$display("%0d errors, %0d assertion failures", errors + 1, dut_i.checker_i.failures);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== sysctl.f ====
common/sysctl_pkg.sv
gpio/sysctl_gpio.sv
timer/sysctl_timer.sv
source/sysctl_cmdport.sv
source/sysctl_csr.sv
source/sysctl.sv
verification/sysctl_checker.sv
verification/sysctl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module sysctl_tb \
	-f sysctl.f -o sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log && exit 0 || exit 1
